// ==== common/pwr_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// domain 0 is the cpu, 1 the peripherals, banks from PWR_FIRST_BANK up
// PWR_DOMAIN_W must hold PWR_NUM_DOMAINS
// ~~~~~~~~~~~~~~~~~~~~

`ifndef PWR_PARAMS_SVH
`define PWR_PARAMS_SVH

// power domains and their index width
`define PWR_NUM_DOMAINS 6
`define PWR_DOMAIN_W 3

`define PWR_CPU_DOMAIN 0
`define PWR_FIRST_BANK 2

// command queue slots
`define PWR_FIFO_DEPTH 4

`endif

// ==== common/pwr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// retain and wake only make sense for memory banks
// ~~~~~~~~~~~~~~~~~~~~

package pwr_pkg;

  typedef enum logic [1:0] {
    OP_OFF    = 2'd0,
    OP_ON     = 2'd1,
    OP_RETAIN = 2'd2,
    OP_WAKE   = 2'd3
  } pwr_op_e;

  // one step per state, except the ack wait
  typedef enum logic [3:0] {
    SEQ_IDLE        = 4'd0,
    SEQ_CLKGATE     = 4'd1,
    SEQ_ISO         = 4'd2,
    SEQ_RST         = 4'd3,
    SEQ_SWITCH      = 4'd4,
    SEQ_WAIT_ACK    = 4'd5,
    SEQ_RELEASE_RST = 4'd6,
    SEQ_RELEASE_ISO = 4'd7,
    SEQ_RELEASE_CLK = 4'd8,
    SEQ_DONE        = 4'd9
  } seq_state_e;

endpackage

// ==== power_manager/pwr_cmd_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// rejected commands are consumed and flagged on err_o one cycle later
// cpu off is checked against core_sleep_i in the accepting cycle
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "pwr_params.svh"

module pwr_cmd_decoder (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     cmd_valid_i,
  input  pwr_pkg::pwr_op_e         cmd_op_i,
  input  logic [`PWR_DOMAIN_W-1:0] cmd_domain_i,
  input  logic                     core_sleep_i,
  output logic                     cmd_ready_o,
  output logic                     err_o,
  output logic                     dec_valid_o,
  output pwr_pkg::pwr_op_e         dec_op_o,
  output logic [`PWR_DOMAIN_W-1:0] dec_domain_o,
  input  logic                     dec_ready_i
);

  localparam logic [`PWR_DOMAIN_W-1:0] NUM_DOM = `PWR_NUM_DOMAINS;
  localparam logic [`PWR_DOMAIN_W-1:0] CPU_DOM = `PWR_CPU_DOMAIN;
  localparam logic [`PWR_DOMAIN_W-1:0] FIRST_BANK = `PWR_FIRST_BANK;

  logic                     dec_valid_q;
  pwr_pkg::pwr_op_e         dec_op_q;
  logic [`PWR_DOMAIN_W-1:0] dec_domain_q;
  logic                     err_q;
  logic                     accept;
  logic                     dom_ok;
  logic                     bank_ok;
  logic                     sleep_ok;
  logic                     legal;

  // single slot, free when empty or draining this cycle
  assign cmd_ready_o = !dec_valid_q || dec_ready_i;
  assign accept      = cmd_valid_i && cmd_ready_o;

  assign dom_ok = cmd_domain_i < NUM_DOM;

  // retention ops on banks only
  assign bank_ok = (cmd_op_i != pwr_pkg::OP_RETAIN && cmd_op_i != pwr_pkg::OP_WAKE) ||
                   (cmd_domain_i >= FIRST_BANK);

  // cpu goes down only while asleep
  assign sleep_ok = !(cmd_op_i == pwr_pkg::OP_OFF && cmd_domain_i == CPU_DOM) ||
                    core_sleep_i;

  assign legal = dom_ok && bank_ok && sleep_ok;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_valid_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      err_q <= accept && !legal;
      if (accept && legal) begin
        dec_valid_q <= 1'b1;
      end else if (dec_ready_i) begin
        dec_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && legal) begin
      dec_op_q     <= cmd_op_i;
      dec_domain_q <= cmd_domain_i;
    end
  end

  assign dec_valid_o  = dec_valid_q;
  assign dec_op_o     = dec_op_q;
  assign dec_domain_o = dec_domain_q;
  assign err_o        = err_q;

endmodule

// ==== power_manager/pwr_cmd_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// wr_ready_o stays low while full, even if a read happens that cycle
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "pwr_params.svh"

module pwr_cmd_fifo (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     wr_valid_i,
  input  pwr_pkg::pwr_op_e         wr_op_i,
  input  logic [`PWR_DOMAIN_W-1:0] wr_domain_i,
  output logic                     wr_ready_o,
  output logic                     rd_valid_o,
  output pwr_pkg::pwr_op_e         rd_op_o,
  output logic [`PWR_DOMAIN_W-1:0] rd_domain_o,
  input  logic                     rd_ready_i
);

  localparam int DEPTH = `PWR_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  pwr_pkg::pwr_op_e         op_mem  [DEPTH];
  logic [`PWR_DOMAIN_W-1:0] dom_mem [DEPTH];
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [CNT_W-1:0]         count_q;
  logic                     push;
  logic                     pop;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_ready_o = count_q != FULL_CNT;
  assign rd_valid_o = count_q != '0;
  assign push       = wr_valid_i && wr_ready_o;
  assign pop        = rd_valid_o && rd_ready_i;

  assign rd_op_o     = op_mem[rd_ptr_q];
  assign rd_domain_o = dom_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_mem[wr_ptr_q]  <= wr_op_i;
      dom_mem[wr_ptr_q] <= wr_domain_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== power_manager/pwr_domain_seq.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// one command at a time, only the selected domain's bits change
// off and on wait for pwrgate_ack_n_i to match the switch, no timeout
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "pwr_params.svh"

module pwr_domain_seq (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        debug_reset_n_i,
  input  logic                        q_valid_i,
  input  pwr_pkg::pwr_op_e            q_op_i,
  input  logic [`PWR_DOMAIN_W-1:0]    q_domain_i,
  output logic                        q_ready_o,
  input  logic [`PWR_NUM_DOMAINS-1:0] pwrgate_ack_n_i,
  output logic [`PWR_NUM_DOMAINS-1:0] pwrgate_n_o,
  output logic [`PWR_NUM_DOMAINS-1:0] iso_n_o,
  output logic [`PWR_NUM_DOMAINS-1:0] rst_n_o,
  output logic [`PWR_NUM_DOMAINS-1:0] clkgate_en_n_o,
  output logic [`PWR_NUM_DOMAINS-1:0] retentive_n_o,
  output logic                        done_o,
  output logic [`PWR_DOMAIN_W-1:0]    done_domain_o
);

  pwr_pkg::seq_state_e             state_q;
  pwr_pkg::seq_state_e             state_d;
  pwr_pkg::pwr_op_e                op_q;
  logic [`PWR_DOMAIN_W-1:0]        dom_q;
  logic [`PWR_NUM_DOMAINS-1:0]     pwrgate_q;
  logic [`PWR_NUM_DOMAINS-1:0]     iso_q;
  logic [`PWR_NUM_DOMAINS-1:0]     rst_q;
  logic [`PWR_NUM_DOMAINS-1:0]     clkgate_q;
  logic [`PWR_NUM_DOMAINS-1:0]     ret_q;
  logic                            take;
  logic                            ack_match;

  assign q_ready_o = state_q == pwr_pkg::SEQ_IDLE;
  assign take      = q_valid_i && q_ready_o;

  // switch settled for the selected domain
  assign ack_match = pwrgate_ack_n_i[dom_q] == pwrgate_q[dom_q];

  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q  <= q_op_i;
      dom_q <= q_domain_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      pwr_pkg::SEQ_IDLE: begin
        if (take) begin
          // going down starts with the clock, coming up with the switch
          if (q_op_i == pwr_pkg::OP_OFF || q_op_i == pwr_pkg::OP_RETAIN) begin
            state_d = pwr_pkg::SEQ_CLKGATE;
          end else begin
            state_d = pwr_pkg::SEQ_SWITCH;
          end
        end
      end
      pwr_pkg::SEQ_CLKGATE: begin
        state_d = pwr_pkg::SEQ_ISO;
      end
      pwr_pkg::SEQ_ISO: begin
        if (op_q == pwr_pkg::OP_OFF) begin
          state_d = pwr_pkg::SEQ_RST;
        end else begin
          state_d = pwr_pkg::SEQ_SWITCH;
        end
      end
      pwr_pkg::SEQ_RST: begin
        state_d = pwr_pkg::SEQ_SWITCH;
      end
      pwr_pkg::SEQ_SWITCH: begin
        case (op_q)
          pwr_pkg::OP_OFF,
          pwr_pkg::OP_ON: state_d = pwr_pkg::SEQ_WAIT_ACK;
          pwr_pkg::OP_RETAIN: state_d = pwr_pkg::SEQ_DONE;
          default: state_d = pwr_pkg::SEQ_RELEASE_ISO;
        endcase
      end
      pwr_pkg::SEQ_WAIT_ACK: begin
        if (ack_match) begin
          if (op_q == pwr_pkg::OP_OFF) begin
            state_d = pwr_pkg::SEQ_DONE;
          end else begin
            state_d = pwr_pkg::SEQ_RELEASE_RST;
          end
        end
      end
      pwr_pkg::SEQ_RELEASE_RST: begin
        state_d = pwr_pkg::SEQ_RELEASE_ISO;
      end
      pwr_pkg::SEQ_RELEASE_ISO: begin
        state_d = pwr_pkg::SEQ_RELEASE_CLK;
      end
      pwr_pkg::SEQ_RELEASE_CLK: begin
        state_d = pwr_pkg::SEQ_DONE;
      end
      default: begin
        state_d = pwr_pkg::SEQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= pwr_pkg::SEQ_IDLE;
      pwrgate_q <= '1;
      iso_q     <= '1;
      rst_q     <= '1;
      clkgate_q <= '1;
      ret_q     <= '1;
    end else begin
      state_q <= state_d;
      case (state_q)
        pwr_pkg::SEQ_CLKGATE: begin
          clkgate_q[dom_q] <= 1'b0;
        end
        pwr_pkg::SEQ_ISO: begin
          iso_q[dom_q] <= 1'b0;
        end
        pwr_pkg::SEQ_RST: begin
          rst_q[dom_q] <= 1'b0;
        end
        pwr_pkg::SEQ_SWITCH: begin
          // banks use the retention bit here, the switch stays put
          case (op_q)
            pwr_pkg::OP_OFF: begin
              pwrgate_q[dom_q] <= 1'b0;
            end
            pwr_pkg::OP_ON: begin
              pwrgate_q[dom_q] <= 1'b1;
              ret_q[dom_q]     <= 1'b1;
            end
            pwr_pkg::OP_RETAIN: begin
              ret_q[dom_q] <= 1'b0;
            end
            default: begin
              ret_q[dom_q] <= 1'b1;
            end
          endcase
        end
        pwr_pkg::SEQ_RELEASE_RST: begin
          rst_q[dom_q] <= 1'b1;
        end
        pwr_pkg::SEQ_RELEASE_ISO: begin
          iso_q[dom_q] <= 1'b1;
        end
        pwr_pkg::SEQ_RELEASE_CLK: begin
          clkgate_q[dom_q] <= 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  assign pwrgate_n_o    = pwrgate_q;
  assign iso_n_o        = iso_q;
  assign clkgate_en_n_o = clkgate_q;
  assign retentive_n_o  = ret_q;

  // debug reset overrides every domain
  assign rst_n_o = rst_q & {`PWR_NUM_DOMAINS{debug_reset_n_i}};

  assign done_o        = state_q == pwr_pkg::SEQ_DONE;
  assign done_domain_o = dom_q;

endmodule

// ==== verilog/mcu_power_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// all control vectors active low, all domains on after reset
// commands finish in the order they were accepted
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "pwr_params.svh"

module mcu_power_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        debug_reset_n_i,
  input  logic                        core_sleep_i,
  input  logic                        cmd_valid_i,
  input  pwr_pkg::pwr_op_e            cmd_op_i,
  input  logic [`PWR_DOMAIN_W-1:0]    cmd_domain_i,
  output logic                        cmd_ready_o,
  output logic                        err_o,
  output logic                        done_o,
  output logic [`PWR_DOMAIN_W-1:0]    done_domain_o,
  input  logic [`PWR_NUM_DOMAINS-1:0] pwrgate_ack_n_i,
  output logic [`PWR_NUM_DOMAINS-1:0] pwrgate_n_o,
  output logic [`PWR_NUM_DOMAINS-1:0] iso_n_o,
  output logic [`PWR_NUM_DOMAINS-1:0] rst_n_o,
  output logic [`PWR_NUM_DOMAINS-1:0] clkgate_en_n_o,
  output logic [`PWR_NUM_DOMAINS-1:0] retentive_n_o
);

  // decoder to queue
  logic                     dec_valid;
  pwr_pkg::pwr_op_e         dec_op;
  logic [`PWR_DOMAIN_W-1:0] dec_domain;
  logic                     dec_ready;

  // queue to sequencer
  logic                     q_valid;
  pwr_pkg::pwr_op_e         q_op;
  logic [`PWR_DOMAIN_W-1:0] q_domain;
  logic                     q_ready;

  pwr_cmd_decoder u_pwr_cmd_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_domain_i (cmd_domain_i),
    .core_sleep_i (core_sleep_i),
    .cmd_ready_o  (cmd_ready_o),
    .err_o        (err_o),
    .dec_valid_o  (dec_valid),
    .dec_op_o     (dec_op),
    .dec_domain_o (dec_domain),
    .dec_ready_i  (dec_ready)
  );

  pwr_cmd_fifo u_pwr_cmd_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_valid_i  (dec_valid),
    .wr_op_i     (dec_op),
    .wr_domain_i (dec_domain),
    .wr_ready_o  (dec_ready),
    .rd_valid_o  (q_valid),
    .rd_op_o     (q_op),
    .rd_domain_o (q_domain),
    .rd_ready_i  (q_ready)
  );

  pwr_domain_seq u_pwr_domain_seq (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .debug_reset_n_i (debug_reset_n_i),
    .q_valid_i       (q_valid),
    .q_op_i          (q_op),
    .q_domain_i      (q_domain),
    .q_ready_o       (q_ready),
    .pwrgate_ack_n_i (pwrgate_ack_n_i),
    .pwrgate_n_o     (pwrgate_n_o),
    .iso_n_o         (iso_n_o),
    .rst_n_o         (rst_n_o),
    .clkgate_en_n_o  (clkgate_en_n_o),
    .retentive_n_o   (retentive_n_o),
    .done_o          (done_o),
    .done_domain_o   (done_domain_o)
  );

endmodule

// ==== tb/mcu_power_ctrl_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// checks off ordering per domain and both command links, outside reset
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "pwr_params.svh"

module mcu_power_ctrl_sva (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        debug_reset_n_i,
  input logic                        cmd_valid_i,
  input logic                        cmd_ready_i,
  input logic [1:0]                  cmd_op_i,
  input logic [`PWR_DOMAIN_W-1:0]    cmd_domain_i,
  input logic                        dec_valid_i,
  input logic                        dec_ready_i,
  input logic [1:0]                  dec_op_i,
  input logic [`PWR_DOMAIN_W-1:0]    dec_domain_i,
  input logic                        done_i,
  input logic [`PWR_NUM_DOMAINS-1:0] pwrgate_n_i,
  input logic [`PWR_NUM_DOMAINS-1:0] iso_n_i,
  input logic [`PWR_NUM_DOMAINS-1:0] rst_n_dom_i,
  input logic [`PWR_NUM_DOMAINS-1:0] clkgate_en_n_i
);

  // failed assertion count
  int fail_cnt = 0;

  // a bit that falls needs the previous step already low
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(iso_n_i) & ~iso_n_i & clkgate_en_n_i) == '0)
    else begin
      $error("isolation asserted while the clock was still running");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !debug_reset_n_i || ($past(rst_n_dom_i) & ~rst_n_dom_i & iso_n_i) == '0)
    else begin
      $error("domain reset asserted before isolation");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(pwrgate_n_i) & ~pwrgate_n_i & rst_n_dom_i) == '0)
    else begin
      $error("switch opened while the domain was out of reset");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_op_i) && $stable(cmd_domain_i))
    else begin
      $error("command payload changed while stalled");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_i && !dec_ready_i |=> dec_valid_i && $stable(dec_op_i) && $stable(dec_domain_i))
    else begin
      $error("decoder payload changed while stalled");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
    else begin
      $error("done held for more than one cycle");
      fail_cnt++;
    end

endmodule

// ==== tb/tb_mcu_power_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// table entry is {op, domain, core_sleep, err, {pwrgate, iso, rst, clkgate, ret}}
// acknowledge follows each switch bit after 0 to 3 cycles plus ack_extra
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "pwr_params.svh"

module tb_mcu_power_ctrl;

  localparam int ND = `PWR_NUM_DOMAINS;
  localparam int NUM_ENTRIES = 9;
  localparam int NUM_BP = 6;
  localparam int CYCLE_LIMIT = 40 * (NUM_ENTRIES + NUM_BP) + 200;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     debug_reset_n_i;
  logic                     core_sleep_i;
  logic                     cmd_valid_i;
  pwr_pkg::pwr_op_e         cmd_op_i;
  logic [`PWR_DOMAIN_W-1:0] cmd_domain_i;
  logic                     cmd_ready_o;
  logic                     err_o;
  logic                     done_o;
  logic [`PWR_DOMAIN_W-1:0] done_domain_o;
  logic [ND-1:0]            pwrgate_ack_n_i;
  logic [ND-1:0]            pwrgate_n_o;
  logic [ND-1:0]            iso_n_o;
  logic [ND-1:0]            rst_n_o;
  logic [ND-1:0]            clkgate_en_n_o;
  logic [ND-1:0]            retentive_n_o;

  logic [11:0] table_q [NUM_ENTRIES] = '{
    {pwr_pkg::OP_OFF,    3'd1, 1'b0, 1'b0, 5'b00001},
    {pwr_pkg::OP_ON,     3'd1, 1'b0, 1'b0, 5'b11111},
    {pwr_pkg::OP_RETAIN, 3'd3, 1'b0, 1'b0, 5'b10100},
    {pwr_pkg::OP_WAKE,   3'd3, 1'b0, 1'b0, 5'b11111},
    {pwr_pkg::OP_RETAIN, 3'd0, 1'b1, 1'b1, 5'b00000},
    {pwr_pkg::OP_OFF,    3'd0, 1'b0, 1'b1, 5'b00000},
    {pwr_pkg::OP_ON,     3'd6, 1'b0, 1'b1, 5'b00000},
    {pwr_pkg::OP_OFF,    3'd0, 1'b1, 1'b0, 5'b00001},
    {pwr_pkg::OP_ON,     3'd0, 1'b0, 1'b0, 5'b11111}
  };
  string names [NUM_ENTRIES] = '{
    "off_periph", "on_periph", "retain_bank3", "wake_bank3", "retain_cpu",
    "off_cpu_awake", "bad_domain", "off_cpu_asleep", "on_cpu"
  };
  // sent back to back in this order
  logic [4:0] bp_cmds [NUM_BP] = '{
    {pwr_pkg::OP_OFF, 3'd1},
    {pwr_pkg::OP_OFF, 3'd2},
    {pwr_pkg::OP_RETAIN, 3'd3},
    {pwr_pkg::OP_OFF, 3'd4},
    {pwr_pkg::OP_ON, 3'd1},
    {pwr_pkg::OP_WAKE, 3'd3}
  };

  // expected control state per domain
  logic [ND-1:0] m_pg = '1;
  logic [ND-1:0] m_iso = '1;
  logic [ND-1:0] m_rst = '1;
  logic [ND-1:0] m_clk = '1;
  logic [ND-1:0] m_ret = '1;

  logic [31:0]   lfsr_q = 32'ha9c6e65a;
  logic [ND-1:0] ack_seen = '1;
  int            ack_wait [ND];
  int            ack_extra = 0;
  int            cycle_cnt = 0;
  int            err_cnt = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  logic          bp_active = 1'b0;
  logic          saw_stall = 1'b0;
  logic [`PWR_DOMAIN_W-1:0] done_log [$];

  mcu_power_ctrl u_mcu_power_ctrl (.*);

  bind mcu_power_ctrl mcu_power_ctrl_sva u_mcu_power_ctrl_sva (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .debug_reset_n_i (debug_reset_n_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_i     (cmd_ready_o),
    .cmd_op_i        (cmd_op_i),
    .cmd_domain_i    (cmd_domain_i),
    .dec_valid_i     (dec_valid),
    .dec_ready_i     (dec_ready),
    .dec_op_i        (dec_op),
    .dec_domain_i    (dec_domain),
    .done_i          (done_o),
    .pwrgate_n_i     (pwrgate_n_o),
    .iso_n_i         (iso_n_o),
    .rst_n_dom_i     (rst_n_o),
    .clkgate_en_n_i  (clkgate_en_n_o)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // one acknowledge delay drawn per switch change
  always @(negedge clk_i) begin
    logic [1:0] dly;
    for (int d = 0; d < ND; d++) begin
      if (pwrgate_n_o[d] !== ack_seen[d]) begin
        ack_seen[d] = pwrgate_n_o[d];
        dly[0] = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        dly[1] = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        ack_wait[d] = dly + ack_extra;
      end
      if (pwrgate_ack_n_i[d] !== ack_seen[d]) begin
        if (ack_wait[d] == 0) begin
          pwrgate_ack_n_i[d] = ack_seen[d];
        end else begin
          ack_wait[d]--;
        end
      end
    end
    if (done_o) begin
      done_log.push_back(done_domain_o);
    end
    if (bp_active && !cmd_ready_o) begin
      saw_stall = 1'b1;
    end
  end

  task automatic check_val(input string tname, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("Fail %s: %s expected %0h actual %0h", tname, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_model(input string tname);
    check_val(tname, "pwrgate_n_o", m_pg, pwrgate_n_o);
    check_val(tname, "iso_n_o", m_iso, iso_n_o);
    check_val(tname, "rst_n_o", m_rst, rst_n_o);
    check_val(tname, "clkgate_en_n_o", m_clk, clkgate_en_n_o);
    check_val(tname, "retentive_n_o", m_ret, retentive_n_o);
  endtask

  task automatic finish_test(input string tname, input int base);
    tests_run++;
    if (err_cnt == base) begin
      $display("test %s: ok", tname);
    end else begin
      tests_failed++;
      $display("test %s: failed", tname);
    end
  endtask

  // runs from a falling edge to the falling edge after the transfer
  task automatic send_cmd(input logic [4:0] cmd, input logic sleep);
    cmd_valid_i  = 1'b1;
    cmd_op_i     = pwr_pkg::pwr_op_e'(cmd[4:3]);
    cmd_domain_i = cmd[2:0];
    core_sleep_i = sleep;
    while (!cmd_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic run_entry(input int i);
    logic [11:0] e;
    logic [`PWR_DOMAIN_W-1:0] dom;
    logic got_err;
    int base;
    e = table_q[i];
    dom = e[9:7];
    base = err_cnt;
    send_cmd(e[11:7], e[6]);
    // err_o belongs to the cycle right after the transfer
    got_err = err_o;
    while (!err_o && !done_o) begin
      @(negedge clk_i);
    end
    check_val(names[i], "err_o", e[5], got_err);
    if (!e[5]) begin
      check_val(names[i], "done_domain_o", dom, done_domain_o);
      m_pg[dom] = e[4];
      m_iso[dom] = e[3];
      m_rst[dom] = e[2];
      m_clk[dom] = e[1];
      m_ret[dom] = e[0];
    end else begin
      // a rejected command must not start a sequence
      repeat (8) begin
        @(negedge clk_i);
        check_val(names[i], "done_o", 1'b0, done_o);
      end
    end
    check_model(names[i]);
    finish_test(names[i], base);
  endtask

  initial begin
    int base;
    int sva_fails;
    rst_n_i         = 1'b0;
    debug_reset_n_i = 1'b1;
    core_sleep_i    = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_op_i        = pwr_pkg::OP_OFF;
    cmd_domain_i    = '0;
    pwrgate_ack_n_i = '1;
    for (int d = 0; d < ND; d++) begin
      ack_wait[d] = 0;
    end
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    base = err_cnt;
    check_val("after_reset", "cmd_ready_o", 1'b1, cmd_ready_o);
    check_val("after_reset", "err_o", 1'b0, err_o);
    check_val("after_reset", "done_o", 1'b0, done_o);
    check_model("after_reset");
    finish_test("after_reset", base);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(i);
    end

    base = err_cnt;
    debug_reset_n_i = 1'b0;
    @(negedge clk_i);
    check_val("debug_reset", "rst_n_o", '0, rst_n_o);
    debug_reset_n_i = 1'b1;
    @(negedge clk_i);
    check_val("debug_reset", "rst_n_o", m_rst, rst_n_o);
    finish_test("debug_reset", base);

    base = err_cnt;
    ack_extra = 6;
    done_log.delete();
    bp_active = 1'b1;
    for (int k = 0; k < NUM_BP; k++) begin
      send_cmd(bp_cmds[k], 1'b0);
    end
    while (done_log.size() < NUM_BP) begin
      @(negedge clk_i);
    end
    bp_active = 1'b0;
    ack_extra = 0;
    assert (saw_stall) else begin
      $display("backpressure: cmd_ready_o never dropped while the queue was full");
      err_cnt++;
    end
    for (int k = 0; k < NUM_BP; k++) begin
      check_val("backpressure", "done_domain_o", bp_cmds[k][2:0], done_log[k]);
    end
    finish_test("backpressure", base);

    sva_fails = u_mcu_power_ctrl.u_mcu_power_ctrl_sva.fail_cnt;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_cnt, sva_fails);
    if (err_cnt == 0 && sva_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+common
common/pwr_pkg.sv
power_manager/pwr_cmd_decoder.sv
power_manager/pwr_cmd_fifo.sv
power_manager/pwr_domain_seq.sv
verilog/mcu_power_ctrl.sv
tb/mcu_power_ctrl_sva.sv
tb/tb_mcu_power_ctrl.sv
